//--- flist.f
+incdir+src
src/axil_pkg.sv
src/axil_skid_buffer.sv
src/axil_const_slv.sv
src/axil_addr_demux.sv
src/axil_subsys_top.sv
tb/axil_subsys_properties.sv
tb/axil_subsys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the AXI4-Lite subsystem testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module axil_subsys_tb -f flist.f -o axil_subsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/axil_subsys_sim +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi

//--- tb/axil_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_consts.svh"

module axil_subsys_tb;

    localparam int unsigned TIMEOUT_CYCLES = 2000;
    localparam logic [1:0]  ORDER_AW_FIRST = 2'd0;
    localparam logic [1:0]  ORDER_W_FIRST  = 2'd1;

    logic          seq = 1'b0;
    logic          rst;
    logic          aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic          ar_valid, ar_ready, r_valid, r_ready;
    axil_pkg::aw_t aw;
    axil_pkg::w_t  w;
    axil_pkg::b_t  b;
    axil_pkg::ar_t ar;
    axil_pkg::r_t  r;

    logic [31:0]   rng_state = 32'hb8db;
    logic [31:0]   stall_mask = 32'h3;
    string         test_name = "init";
    logic [1:0]    exp_b_resp;
    logic [1:0]    exp_r_resp;
    logic [31:0]   exp_r_data;
    int unsigned   wr_issued = 0;
    int unsigned   rd_issued = 0;
    int unsigned   b_seen = 0;
    int unsigned   r_seen = 0;
    int unsigned   cycle_count = 0;

    axil_subsys_top axil_subsys_top_inst (
        .seq(seq), .rst(rst),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
        .w_valid(w_valid), .w_ready(w_ready), .w(w),
        .b_valid(b_valid), .b_ready(b_ready), .b(b),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .r_valid(r_valid), .r_ready(r_ready), .r(r)
    );

    bind axil_subsys_top axil_subsys_properties props_inst (
        .seq(seq), .rst(rst),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .w_valid(w_valid), .w_ready(w_ready),
        .b_valid(b_valid), .b_ready(b_ready), .b(b),
        .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_ready(r_ready), .r(r)
    );

    always #2 seq = ~seq;

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Word of the target that owns addr or zero outside both windows
    function automatic logic [31:0] target_word(input logic [31:0] addr);
        if (addr < `AXIL_SLV0_END) return `AXIL_SLV0_DATA;
        if (addr < `AXIL_SLV1_END) return `AXIL_SLV1_DATA;
        return 32'h0;
    endfunction

    function automatic logic [31:0] pick_addr(input logic [1:0] region, input logic [31:0] rnd);
        case (region)
            2'd0:    return rnd & 32'h0000_0FFC;
            2'd1:    return `AXIL_SLV1_START | (rnd & 32'h0000_0FFC);
            default: return `AXIL_SLV1_END + (rnd & 32'h00FF_FFFC);
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", test_name, what, expected, actual);
        $display("Verification failed");
        $fatal(1, "Value mismatch");
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(negedge seq);
        rst = 1'b0;
    endtask

    // Stalls count down only while the response is waiting
    task automatic await_b();
        logic [31:0] stall;
        logic        done;
        stall = next_rand() & stall_mask;
        done  = 1'b0;
        while (!done) begin
            b_ready = (stall == 0);
            done    = b_valid && b_ready;
            if (b_valid && stall != 0) stall = stall - 1;
            @(negedge seq);
        end
    endtask

    task automatic await_r();
        logic [31:0] stall;
        logic        done;
        stall = next_rand() & stall_mask;
        done  = 1'b0;
        while (!done) begin
            r_ready = (stall == 0);
            done    = r_valid && r_ready;
            if (r_valid && stall != 0) stall = stall - 1;
            @(negedge seq);
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] order);
        logic aw_left;
        logic w_left;
        logic aw_go;
        logic w_go;
        if (addr >= `AXIL_SLV1_END) exp_b_resp = axil_pkg::DECERR;
        else if (data == target_word(addr) && strb == 4'hF) exp_b_resp = axil_pkg::OKAY;
        else exp_b_resp = axil_pkg::SLVERR;
        aw_left = 1'b1;
        w_left  = 1'b1;
        aw      = '{addr: addr, prot: 3'b000};
        w       = '{data: data, strb: strb};
        while (aw_left || w_left) begin
            aw_valid = aw_left && (order != ORDER_W_FIRST || !w_left);
            w_valid  = w_left && (order != ORDER_AW_FIRST || !aw_left);
            aw_go    = aw_valid && aw_ready;     // Ready only changes on the rising edge
            w_go     = w_valid && w_ready;
            @(negedge seq);
            if (aw_go) aw_left = 1'b0;
            if (w_go) w_left = 1'b0;
        end
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        wr_issued++;
        await_b();
    endtask

    task automatic do_read(input logic [31:0] addr);
        logic [31:0] rnd;
        rnd        = next_rand();
        exp_r_data = target_word(addr);
        exp_r_resp = (addr >= `AXIL_SLV1_END) ? axil_pkg::DECERR : axil_pkg::OKAY;
        ar_valid   = 1'b1;
        ar         = '{addr: addr, prot: rnd[2:0]};
        while (!ar_ready) @(negedge seq);
        @(negedge seq);
        ar_valid = 1'b0;
        rd_issued++;
        await_r();
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////
    bresp_check: assert property (@(posedge seq) disable iff (rst)
        (b_valid && b_ready) |-> (b.resp == exp_b_resp))
        else report_mismatch("bresp", {30'd0, $sampled(exp_b_resp)},
                             {30'd0, $sampled(b.resp)});

    rresp_check: assert property (@(posedge seq) disable iff (rst)
        (r_valid && r_ready) |-> (r.resp == exp_r_resp))
        else report_mismatch("rresp", {30'd0, $sampled(exp_r_resp)},
                             {30'd0, $sampled(r.resp)});

    rdata_check: assert property (@(posedge seq) disable iff (rst)
        (r_valid && r_ready) |-> (r.data == exp_r_data))
        else report_mismatch("rdata", $sampled(exp_r_data), $sampled(r.data));

    always @(posedge seq) begin
        if (!rst && b_valid && b_ready) b_seen <= b_seen + 1;
        if (!rst && r_valid && r_ready) r_seen <= r_seen + 1;
    end

    always @(posedge seq) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Verification failed");
            $fatal(1, "Timeout");
        end
    end

    always @(negedge seq) begin
        if (axil_subsys_top_inst.props_inst.fail_count != 0) begin
            $display("A protocol assertion on the DUT ports failed");
            $display("Verification failed");
            $fatal(1, "Protocol assertion failure");
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] rnd;
        rst      = 1'b1;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b1;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b1;
        test_name = "reset";
        apply_reset();

        test_name = "read_window";
        do_read(32'h0000_0000);
        do_read(32'h0000_0FFC);
        do_read(32'h0000_1000);
        do_read(32'h0000_1FFC);
        for (int i = 0; i < 4; i++) begin
            do_read(pick_addr({1'b0, i[0]}, next_rand()));
        end

        // Good word, wrong word and partial strobe for each order
        test_name = "write_check";
        for (int t = 0; t < 2; t++) begin
            for (int o = 0; o < 3; o++) begin
                addr = pick_addr({1'b0, t[0]}, next_rand());
                word = target_word(addr);
                do_write(addr, word, 4'hF, o[1:0]);
                do_write(addr, word ^ 32'h0000_0100, 4'hF, o[1:0]);
                do_write(addr, word, 4'b1011, o[1:0]);
            end
        end

        test_name = "decode_error";
        do_read(32'h0000_2000);
        do_write(32'h0000_2000, `AXIL_SLV0_DATA, 4'hF, ORDER_AW_FIRST);
        for (int i = 0; i < 3; i++) begin
            addr = pick_addr(2'd2, next_rand());
            do_read(addr);
            do_write(addr, next_rand(), 4'hF, i[1:0]);
        end

        // A write and a read response are left waiting so that reset has to clear them
        test_name = "mid_reset";
        b_ready   = 1'b0;
        r_ready   = 1'b0;
        while (!(aw_ready && w_ready && ar_ready)) @(negedge seq);
        aw_valid  = 1'b1;
        aw        = '{addr: `AXIL_SLV0_START, prot: 3'b000};
        w_valid   = 1'b1;
        w         = '{data: `AXIL_SLV0_DATA, strb: 4'hF};
        ar_valid  = 1'b1;
        ar        = '{addr: `AXIL_SLV1_START, prot: 3'b000};
        @(negedge seq);
        aw_valid  = 1'b0;
        w_valid   = 1'b0;
        ar_valid  = 1'b0;
        while (!(b_valid && r_valid)) @(negedge seq);
        apply_reset();
        b_ready   = 1'b1;
        r_ready   = 1'b1;

        test_name  = "back_pressure";
        stall_mask = 32'h7;
        for (int i = 0; i < 24; i++) begin
            rnd  = next_rand();
            addr = pick_addr(rnd[2:1], next_rand());
            if (rnd[0]) begin
                do_read(addr);
            end else begin
                word = rnd[3] ? target_word(addr) : next_rand();
                do_write(addr, word, rnd[4] ? 4'hF : {rnd[7:5], 1'b1}, rnd[9:8]);
            end
        end

        test_name = "response_count";
        repeat (4) @(negedge seq);
        wr_count_check: assert (b_seen == wr_issued)
            else report_mismatch("write responses", wr_issued, b_seen);
        rd_count_check: assert (r_seen == rd_issued)
            else report_mismatch("read responses", rd_issued, r_seen);

        if (axil_subsys_top_inst.props_inst.fail_count != 0) begin
            $display("Protocol assertions failed during the run");
            $display("Verification failed");
            $fatal(1, "Protocol assertion failure");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/axil_subsys_properties.sv
`timescale 1ns/1ps
`default_nettype none

module axil_subsys_properties (
    input logic         seq,
    input logic         rst,
    input logic         aw_valid,
    input logic         aw_ready,
    input logic         w_valid,
    input logic         w_ready,
    input logic         b_valid,
    input logic         b_ready,
    input axil_pkg::b_t b,
    input logic         ar_valid,
    input logic         ar_ready,
    input logic         r_valid,
    input logic         r_ready,
    input axil_pkg::r_t r
);

    int unsigned fail_count = 0;
    logic [15:0] aw_count;
    logic [15:0] w_count;
    logic [15:0] b_count;
    logic [15:0] ar_count;
    logic [15:0] r_count;

    // Handshake counts on the manager side
    always_ff @(posedge seq) begin
        if (rst) begin
            aw_count <= '0;
            w_count  <= '0;
            b_count  <= '0;
            ar_count <= '0;
            r_count  <= '0;
        end else begin
            if (aw_valid && aw_ready) aw_count <= aw_count + 16'd1;
            if (w_valid && w_ready) w_count <= w_count + 16'd1;
            if (b_valid && b_ready) b_count <= b_count + 16'd1;
            if (ar_valid && ar_ready) ar_count <= ar_count + 16'd1;
            if (r_valid && r_ready) r_count <= r_count + 16'd1;
        end
    end

    //////////////////////////////
    // Response channels
    //////////////////////////////
    b_hold: assert property (@(posedge seq) disable iff (rst)
        (b_valid && !b_ready) |=> (b_valid && $stable(b)))
        else begin
            $error("Write response dropped or changed while bready was low");
            fail_count++;
        end

    r_hold: assert property (@(posedge seq) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
        else begin
            $error("Read response dropped or changed while rready was low");
            fail_count++;
        end

    b_needs_request: assert property (@(posedge seq) disable iff (rst)
        b_valid |-> ((aw_count > b_count) && (w_count > b_count)))
        else begin
            $error("Write response without an outstanding write");
            fail_count++;
        end

    r_needs_request: assert property (@(posedge seq) disable iff (rst)
        r_valid |-> (ar_count > r_count))
        else begin
            $error("Read response without an outstanding read");
            fail_count++;
        end

    // First cycle out of reset
    idle_after_reset: assert property (@(posedge seq) $fell(rst) |-> (!b_valid && !r_valid))
        else begin
            $error("Response valid high in the cycle after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- src/axil_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_consts.svh"

module axil_subsys_top (
    input  logic          seq,
    input  logic          rst,

    input  logic          aw_valid,
    output logic          aw_ready,
    input  axil_pkg::aw_t aw,
    input  logic          w_valid,
    output logic          w_ready,
    input  axil_pkg::w_t  w,
    output logic          b_valid,
    input  logic          b_ready,
    output axil_pkg::b_t  b,
    input  logic          ar_valid,
    output logic          ar_ready,
    input  axil_pkg::ar_t ar,
    output logic          r_valid,
    input  logic          r_ready,
    output axil_pkg::r_t  r
);

    // Request channels after the skid buffers
    logic          aw_s_valid, aw_s_ready;
    logic          w_s_valid, w_s_ready;
    logic          ar_s_valid, ar_s_ready;
    axil_pkg::aw_t aw_s;
    axil_pkg::w_t  w_s;
    axil_pkg::ar_t ar_s;

    logic          t0_aw_valid, t0_aw_ready, t0_w_valid, t0_w_ready, t0_b_valid, t0_b_ready;
    logic          t0_ar_valid, t0_ar_ready, t0_r_valid, t0_r_ready;
    axil_pkg::aw_t t0_aw;
    axil_pkg::w_t  t0_w;
    axil_pkg::b_t  t0_b;
    axil_pkg::ar_t t0_ar;
    axil_pkg::r_t  t0_r;

    logic          t1_aw_valid, t1_aw_ready, t1_w_valid, t1_w_ready, t1_b_valid, t1_b_ready;
    logic          t1_ar_valid, t1_ar_ready, t1_r_valid, t1_r_ready;
    axil_pkg::aw_t t1_aw;
    axil_pkg::w_t  t1_w;
    axil_pkg::b_t  t1_b;
    axil_pkg::ar_t t1_ar;
    axil_pkg::r_t  t1_r;

    //////////////////////////////
    // Inbound request buffering
    //////////////////////////////
    axil_skid_buffer #(.payload_t(axil_pkg::aw_t)) aw_skid_inst (
        .seq(seq), .rst(rst),
        .in_valid(aw_valid), .in_ready(aw_ready), .in_data(aw),
        .out_valid(aw_s_valid), .out_ready(aw_s_ready), .out_data(aw_s)
    );

    axil_skid_buffer #(.payload_t(axil_pkg::w_t)) w_skid_inst (
        .seq(seq), .rst(rst),
        .in_valid(w_valid), .in_ready(w_ready), .in_data(w),
        .out_valid(w_s_valid), .out_ready(w_s_ready), .out_data(w_s)
    );

    axil_skid_buffer #(.payload_t(axil_pkg::ar_t)) ar_skid_inst (
        .seq(seq), .rst(rst),
        .in_valid(ar_valid), .in_ready(ar_ready), .in_data(ar),
        .out_valid(ar_s_valid), .out_ready(ar_s_ready), .out_data(ar_s)
    );

    //////////////////////////////
    // Decoder and targets
    //////////////////////////////
    axil_addr_demux axil_addr_demux_inst (
        .seq(seq), .rst(rst),
        .aw_valid(aw_s_valid), .aw_ready(aw_s_ready), .aw(aw_s),
        .w_valid(w_s_valid), .w_ready(w_s_ready), .w(w_s),
        .b_valid(b_valid), .b_ready(b_ready), .b(b),
        .ar_valid(ar_s_valid), .ar_ready(ar_s_ready), .ar(ar_s),
        .r_valid(r_valid), .r_ready(r_ready), .r(r),
        .t0_aw_valid(t0_aw_valid), .t0_aw_ready(t0_aw_ready), .t0_aw(t0_aw),
        .t0_w_valid(t0_w_valid), .t0_w_ready(t0_w_ready), .t0_w(t0_w),
        .t0_b_valid(t0_b_valid), .t0_b_ready(t0_b_ready), .t0_b(t0_b),
        .t0_ar_valid(t0_ar_valid), .t0_ar_ready(t0_ar_ready), .t0_ar(t0_ar),
        .t0_r_valid(t0_r_valid), .t0_r_ready(t0_r_ready), .t0_r(t0_r),
        .t1_aw_valid(t1_aw_valid), .t1_aw_ready(t1_aw_ready), .t1_aw(t1_aw),
        .t1_w_valid(t1_w_valid), .t1_w_ready(t1_w_ready), .t1_w(t1_w),
        .t1_b_valid(t1_b_valid), .t1_b_ready(t1_b_ready), .t1_b(t1_b),
        .t1_ar_valid(t1_ar_valid), .t1_ar_ready(t1_ar_ready), .t1_ar(t1_ar),
        .t1_r_valid(t1_r_valid), .t1_r_ready(t1_r_ready), .t1_r(t1_r)
    );

    axil_const_slv #(.RESP_DATA(`AXIL_SLV0_DATA)) slv0_inst (
        .seq(seq), .rst(rst),
        .aw_valid(t0_aw_valid), .aw_ready(t0_aw_ready), .aw(t0_aw),
        .w_valid(t0_w_valid), .w_ready(t0_w_ready), .w(t0_w),
        .b_valid(t0_b_valid), .b_ready(t0_b_ready), .b(t0_b),
        .ar_valid(t0_ar_valid), .ar_ready(t0_ar_ready), .ar(t0_ar),
        .r_valid(t0_r_valid), .r_ready(t0_r_ready), .r(t0_r)
    );

    axil_const_slv #(.RESP_DATA(`AXIL_SLV1_DATA)) slv1_inst (
        .seq(seq), .rst(rst),
        .aw_valid(t1_aw_valid), .aw_ready(t1_aw_ready), .aw(t1_aw),
        .w_valid(t1_w_valid), .w_ready(t1_w_ready), .w(t1_w),
        .b_valid(t1_b_valid), .b_ready(t1_b_ready), .b(t1_b),
        .ar_valid(t1_ar_valid), .ar_ready(t1_ar_ready), .ar(t1_ar),
        .r_valid(t1_r_valid), .r_ready(t1_r_ready), .r(t1_r)
    );

endmodule

`default_nettype wire

//--- src/axil_addr_demux.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_consts.svh"

module axil_addr_demux (
    input  logic          seq,
    input  logic          rst,

    input  logic          aw_valid,
    output logic          aw_ready,
    input  axil_pkg::aw_t aw,
    input  logic          w_valid,
    output logic          w_ready,
    input  axil_pkg::w_t  w,
    output logic          b_valid,
    input  logic          b_ready,
    output axil_pkg::b_t  b,
    input  logic          ar_valid,
    output logic          ar_ready,
    input  axil_pkg::ar_t ar,
    output logic          r_valid,
    input  logic          r_ready,
    output axil_pkg::r_t  r,

    output logic          t0_aw_valid,
    input  logic          t0_aw_ready,
    output axil_pkg::aw_t t0_aw,
    output logic          t0_w_valid,
    input  logic          t0_w_ready,
    output axil_pkg::w_t  t0_w,
    input  logic          t0_b_valid,
    output logic          t0_b_ready,
    input  axil_pkg::b_t  t0_b,
    output logic          t0_ar_valid,
    input  logic          t0_ar_ready,
    output axil_pkg::ar_t t0_ar,
    input  logic          t0_r_valid,
    output logic          t0_r_ready,
    input  axil_pkg::r_t  t0_r,

    output logic          t1_aw_valid,
    input  logic          t1_aw_ready,
    output axil_pkg::aw_t t1_aw,
    output logic          t1_w_valid,
    input  logic          t1_w_ready,
    output axil_pkg::w_t  t1_w,
    input  logic          t1_b_valid,
    output logic          t1_b_ready,
    input  axil_pkg::b_t  t1_b,
    output logic          t1_ar_valid,
    input  logic          t1_ar_ready,
    output axil_pkg::ar_t t1_ar,
    input  logic          t1_r_valid,
    output logic          t1_r_ready,
    input  axil_pkg::r_t  t1_r
);

    localparam logic [1:0] ROUTE_T0   = 2'd0;
    localparam logic [1:0] ROUTE_T1   = 2'd1;
    localparam logic [1:0] ROUTE_MISS = 2'd2;

    function automatic logic [1:0] decode(input logic [`AXIL_ADDR_W-1:0] addr);
        if (addr >= `AXIL_SLV0_START && addr < `AXIL_SLV0_END) begin
            return ROUTE_T0;
        end
        if (addr >= `AXIL_SLV1_START && addr < `AXIL_SLV1_END) begin
            return ROUTE_T1;
        end
        return ROUTE_MISS;
    endfunction

    axil_pkg::aw_t aw_q;
    axil_pkg::aw_t aw_cur;
    axil_pkg::w_t  w_q;
    axil_pkg::ar_t ar_q;
    logic          aw_held;
    logic          w_held;
    logic          wr_busy;
    logic          rd_busy;
    logic          dec_b_valid;
    logic          dec_r_valid;
    logic [1:0]    wr_route;
    logic [1:0]    rd_route;
    logic [1:0]    wr_dest;
    logic [1:0]    rd_dest;
    logic          aw_fire;
    logic          w_fire;
    logic          ar_fire;
    logic          wr_launch;

    //////////////////////////////
    // Write request routing
    //////////////////////////////
    assign aw_ready  = !aw_held && !wr_busy;
    assign w_ready   = !w_held && !wr_busy;
    assign aw_fire   = aw_valid && aw_ready;
    assign w_fire    = w_valid && w_ready;
    assign wr_launch = (aw_held || aw_fire) && (w_held || w_fire);
    assign aw_cur    = aw_fire ? aw : aw_q;
    assign wr_dest   = decode(aw_cur.addr);

    assign t0_aw = aw_q;
    assign t1_aw = aw_q;
    assign t0_w  = w_q;
    assign t1_w  = w_q;

    always_ff @(posedge seq) begin
        if (rst) begin
            aw_held     <= 1'b0;
            w_held      <= 1'b0;
            wr_busy     <= 1'b0;
            wr_route    <= ROUTE_MISS;
            dec_b_valid <= 1'b0;
            t0_aw_valid <= 1'b0;
            t0_w_valid  <= 1'b0;
            t1_aw_valid <= 1'b0;
            t1_w_valid  <= 1'b0;
        end else begin
            if (t0_aw_ready) t0_aw_valid <= 1'b0;
            if (t0_w_ready) t0_w_valid <= 1'b0;
            if (t1_aw_ready) t1_aw_valid <= 1'b0;
            if (t1_w_ready) t1_w_valid <= 1'b0;
            if (b_valid && b_ready) begin
                wr_busy     <= 1'b0;
                dec_b_valid <= 1'b0;
            end
            if (wr_launch) begin
                aw_held  <= 1'b0;
                w_held   <= 1'b0;
                wr_busy  <= 1'b1;                // Held until the b handshake
                wr_route <= wr_dest;
                case (wr_dest)
                    ROUTE_T0: begin
                        t0_aw_valid <= 1'b1;
                        t0_w_valid  <= 1'b1;
                    end
                    ROUTE_T1: begin
                        t1_aw_valid <= 1'b1;
                        t1_w_valid  <= 1'b1;
                    end
                    default: dec_b_valid <= 1'b1;
                endcase
            end else begin
                if (aw_fire) aw_held <= 1'b1;
                if (w_fire) w_held <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Read request routing
    //////////////////////////////
    assign ar_ready = !rd_busy;
    assign ar_fire  = ar_valid && ar_ready;
    assign rd_dest  = decode(ar.addr);
    assign t0_ar    = ar_q;
    assign t1_ar    = ar_q;

    always_ff @(posedge seq) begin
        if (rst) begin
            rd_busy     <= 1'b0;
            rd_route    <= ROUTE_MISS;
            dec_r_valid <= 1'b0;
            t0_ar_valid <= 1'b0;
            t1_ar_valid <= 1'b0;
        end else begin
            if (t0_ar_ready) t0_ar_valid <= 1'b0;
            if (t1_ar_ready) t1_ar_valid <= 1'b0;
            if (r_valid && r_ready) begin
                rd_busy     <= 1'b0;
                dec_r_valid <= 1'b0;
            end
            if (ar_fire) begin
                rd_busy  <= 1'b1;
                rd_route <= rd_dest;
                case (rd_dest)
                    ROUTE_T0: t0_ar_valid <= 1'b1;
                    ROUTE_T1: t1_ar_valid <= 1'b1;
                    default:  dec_r_valid <= 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge seq) begin
        if (aw_fire) aw_q <= aw;
        if (w_fire) w_q <= w;
        if (ar_fire) ar_q <= ar;
    end

    //////////////////////////////
    // Response return
    //////////////////////////////
    always_comb begin
        b_valid    = dec_b_valid;
        b          = '{resp: axil_pkg::DECERR};
        t0_b_ready = 1'b0;
        t1_b_ready = 1'b0;
        case (wr_route)
            ROUTE_T0: begin
                b_valid    = t0_b_valid;
                b          = t0_b;
                t0_b_ready = b_ready;
            end
            ROUTE_T1: begin
                b_valid    = t1_b_valid;
                b          = t1_b;
                t1_b_ready = b_ready;
            end
            default: ;
        endcase
    end

    always_comb begin
        r_valid    = dec_r_valid;
        r          = '{data: '0, resp: axil_pkg::DECERR};   // Misses read as zero
        t0_r_ready = 1'b0;
        t1_r_ready = 1'b0;
        case (rd_route)
            ROUTE_T0: begin
                r_valid    = t0_r_valid;
                r          = t0_r;
                t0_r_ready = r_ready;
            end
            ROUTE_T1: begin
                r_valid    = t1_r_valid;
                r          = t1_r;
                t1_r_ready = r_ready;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/axil_const_slv.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_consts.svh"

module axil_const_slv #(
    parameter logic [`AXIL_DATA_W-1:0] RESP_DATA = `AXIL_SLV0_DATA
) (
    input  logic           seq,
    input  logic           rst,

    input  logic           aw_valid,
    output logic           aw_ready,
    input  axil_pkg::aw_t  aw,

    input  logic           w_valid,
    output logic           w_ready,
    input  axil_pkg::w_t   w,

    output logic           b_valid,
    input  logic           b_ready,
    output axil_pkg::b_t   b,

    input  logic           ar_valid,
    output logic           ar_ready,
    input  axil_pkg::ar_t  ar,

    output logic           r_valid,
    input  logic           r_ready,
    output axil_pkg::r_t   r
);

    logic aw_held;
    logic w_held;
    logic w_ok_q;
    logic aw_fire;
    logic w_fire;
    logic w_ok;
    logic wr_done;

    //////////////////////////////
    // Write channel
    //////////////////////////////
    assign aw_ready = !aw_held && !b_valid;
    assign w_ready  = !w_held && !b_valid;
    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;

    // Only the outcome of the data check is kept, not the data
    assign w_ok    = w_fire ? ((w.data == RESP_DATA) && (&w.strb)) : w_ok_q;
    assign wr_done = (aw_held || aw_fire) && (w_held || w_fire);

    always_ff @(posedge seq) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (wr_done) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                b_valid <= 1'b1;
            end else begin
                if (aw_fire) aw_held <= 1'b1;   // Address came first
                if (w_fire) w_held <= 1'b1;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (w_fire) begin
            w_ok_q <= w_ok;
        end
        if (wr_done) begin
            b.resp <= w_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
        end
    end

    //////////////////////////////
    // Read channel
    //////////////////////////////
    assign ar_ready = !r_valid;
    assign r        = '{data: RESP_DATA, resp: axil_pkg::OKAY};

    always_ff @(posedge seq) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (ar_valid && ar_ready) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/axil_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module axil_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     seq,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // Ready depends only on the fill level, never on out_ready
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge seq) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge seq) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- src/axil_pkg.sv
`default_nettype none

`include "axil_consts.svh"

package axil_pkg;

    // Encodings follow the AXI4 RRESP/BRESP values
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
        logic [`AXIL_PROT_W-1:0] prot;
    } aw_t;

    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
        logic [`AXIL_PROT_W-1:0] prot;
    } ar_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_STRB_W-1:0] strb;
    } w_t;

    typedef struct packed {
        resp_e resp;
    } b_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] data;
        resp_e                   resp;
    } r_t;

endpackage

`default_nettype wire

//--- src/axil_consts.svh
`ifndef AXIL_CONSTS_SVH
`define AXIL_CONSTS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)
`define AXIL_PROT_W 3

//////////////////////////////
// Address map with half-open windows
//////////////////////////////
`define AXIL_SLV0_START 32'h0000_0000
`define AXIL_SLV0_END   32'h0000_1000
`define AXIL_SLV0_DATA  32'h0000_FFFF

`define AXIL_SLV1_START 32'h0000_1000
`define AXIL_SLV1_END   32'h0000_2000
`define AXIL_SLV1_DATA  32'hA5A5_0001

`endif
